// ==== mipsLite_defs.svh ====
`ifndef MIPSLITE_DEFS_SVH
`define MIPSLITE_DEFS_SVH

////////////////////
// opcodes
////////////////////

// R-type shares one opcode, funct picks the op
`define opcodeR     6'b000000
`define opcodeORI   6'b001101
`define opcodeLW    6'b100011
`define opcodeSW    6'b101011
`define opcodeBEQ   6'b000100
`define opcodeLUI   6'b001111
`define opcodeJAL   6'b000011
`define opcodeJ     6'b000010

// funct field of R-type
`define functADDU   6'b100001
`define functSUBU   6'b100011
`define functSLL    6'b000000
`define functJR     6'b001000

////////////////////
// alu and sl codes
////////////////////

// zero is left free, unknown decodes give a zero result
`define aluAdd      8'h01
`define aluSub      8'h02
`define aluSll      8'h03
`define aluOr       8'h04
`define aluEq       8'h05

// only whole-word accesses here
`define slword      3'b001

////////////////////
// sizing
////////////////////

// data memory words, power of two
`define dataDepth   64
// first pc after reset
`define resetPc     32'h00003000

`endif

// ==== isaPkg.sv ====
package isaPkg;

	// basic datum, also pc and addresses
	typedef logic [31:0] word;

	// register number
	typedef logic [4:0] regAddr;

	// instruction fields
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// alu select, see alu codes in the defs header
	typedef logic [7:0] aluCtrlT;

	// extender mode
	// 00 zero, 01 sign, 10 upper half
	typedef logic [1:0] extCtrlT;

	// load/store width code
	typedef logic [2:0] slCtrlT;

	// destination select
	// 00 rd, 01 rt, 10 link register
	typedef logic [1:0] a3SelT;

endpackage

// ==== corePkg.sv ====
package corePkg;

	// execute stage condition
	// execWait when a result sits ready but commit is full
	typedef enum logic
	{
		execIdle,
		execWait
	} execStateT;

endpackage

// ==== mainController.sv ====
`timescale 1ns/1ps
`include "mipsLite_defs.svh"

module mainController import isaPkg::*; (
	input opcodeT Opcode,
	input functT Funct,
	output logic IsBr,
	output logic Jump,
	output logic JType,
	output logic DImmSel,
	output a3SelT A3Sel,
	output logic ALUBSel,
	output logic EResultSel,
	output logic DMWE,
	output logic DataWBSel,
	output logic RegWE,
	output extCtrlT EXTCtrl,
	output aluCtrlT ALUCtrl,
	output slCtrlT SLCtrl
);

	// flag bits, msb first
	// isBr jump jType dImm a3Sel aluB eRes dmWe dataWb regWe ext
	logic [12:0] flags;
	aluCtrlT aluSel;
	slCtrlT slSel;

	assign {IsBr, Jump, JType, DImmSel, A3Sel, ALUBSel, EResultSel,
		DMWE, DataWBSel, RegWE, EXTCtrl} = flags;
	assign ALUCtrl = aluSel;
	assign SLCtrl = slSel;

	always_comb
	begin
		// anything not listed decodes as a no-op
		flags = '0;
		aluSel = '0;
		slSel = '0;
		case (Opcode)
			`opcodeR:
			begin
				case (Funct)
					`functADDU:
					begin
						flags = 13'b0_0_0_0_00_0_0_0_0_1_00;
						aluSel = `aluAdd;
					end
					`functSUBU:
					begin
						flags = 13'b0_0_0_0_00_0_0_0_0_1_00;
						aluSel = `aluSub;
					end
					`functSLL:
					begin
						flags = 13'b0_0_0_0_00_0_0_0_0_1_00;
						aluSel = `aluSll;
					end
					// register jump, target comes from rs
					`functJR:
						flags = 13'b0_1_0_0_00_0_0_0_0_0_00;
					default:
						flags = '0;
				endcase
			end
			`opcodeORI:
			begin
				flags = 13'b0_0_0_0_01_1_0_0_0_1_00;
				aluSel = `aluOr;
			end
			`opcodeLW:
			begin
				flags = 13'b0_0_0_0_01_1_0_0_1_1_01;
				aluSel = `aluAdd;
				slSel = `slword;
			end
			`opcodeSW:
			begin
				flags = 13'b0_0_0_0_00_1_0_1_0_0_01;
				aluSel = `aluAdd;
				slSel = `slword;
			end
			`opcodeBEQ:
			begin
				flags = 13'b1_0_0_0_00_0_0_0_0_0_00;
				aluSel = `aluEq;
			end
			// upper immediate goes straight through the extender
			`opcodeLUI:
				flags = 13'b0_0_0_0_01_1_1_0_0_1_10;
			// link value pc+4 into r31
			`opcodeJAL:
				flags = 13'b0_1_1_1_10_0_1_0_0_1_00;
			`opcodeJ:
				flags = 13'b0_1_1_0_00_0_0_0_0_0_00;
			default:
				flags = '0;
		endcase
	end

endmodule

// ==== instrIntake.sv ====
`timescale 1ns/1ps

module instrIntake import isaPkg::*; (
	input logic clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input word inInstr,
	input word inPc,
	output logic issueValid,
	input logic issueReady,
	output word issueInstr,
	output word issuePc
);

	logic full;
	// goes high one edge after reset lifts
	logic live;
	logic accept;

	// free slot, or the held entry leaves this cycle
	assign inReady = live && (!full || issueReady);
	assign accept = inValid && inReady;
	assign issueValid = full;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			full <= 1'b0;
			live <= 1'b0;
		end
		else
		begin
			live <= 1'b1;
			if (accept)
				full <= 1'b1;
			else if (issueReady)
				full <= 1'b0;
		end
	end

	// instr and pc always move as a pair
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			issueInstr <= inInstr;
			issuePc <= inPc;
		end
	end

endmodule

// ==== execCore.sv ====
`timescale 1ns/1ps
`include "mipsLite_defs.svh"

module execCore import isaPkg::*, corePkg::*; (
	input logic clk,
	input logic arstN,
	input logic issueValid,
	output logic issueReady,
	input word issueInstr,
	input word issuePc,
	output logic commitValid,
	input logic commitReady,
	output word commitPc,
	output word commitNextPc,
	output logic commitRegWe,
	output regAddr commitWrReg,
	output word commitWrData,
	output logic commitMemWe,
	output word commitMemAddr,
	output word commitMemData
);

	localparam int memIdxW = $clog2(`dataDepth);

	execStateT execState;
	logic execValid, handoff;
	word exInstr, exPc;
	word rf [32];
	word dmem [`dataDepth];
	logic isBr, jump, jType, dImmSel, aluBSel, eResultSel, dmWe, dataWbSel, regWe;
	a3SelT a3Sel;
	extCtrlT extCtrl;
	aluCtrlT aluCtrl;
	slCtrlT slCtrl;
	word rsVal, rtVal, extOut, aluB, aluResult, pcPlus4, eResult, memRdData, wbData, nextPc;
	regAddr wrReg;
	logic [memIdxW-1:0] memIdx;
	logic memWe;

	mainController u_mainController (
		.Opcode(exInstr[31:26]), .Funct(exInstr[5:0]),
		.IsBr(isBr), .Jump(jump), .JType(jType), .DImmSel(dImmSel),
		.A3Sel(a3Sel), .ALUBSel(aluBSel), .EResultSel(eResultSel), .DMWE(dmWe),
		.DataWBSel(dataWbSel), .RegWE(regWe), .EXTCtrl(extCtrl),
		.ALUCtrl(aluCtrl), .SLCtrl(slCtrl)
	);

	////////////////////
	// stage handshake
	////////////////////

	// a blocked result keeps the stage closed until commit frees up
	assign issueReady = (execState == execWait) ? commitReady : (!execValid || commitReady);
	assign commitValid = execValid;
	assign handoff = execValid && commitReady;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			execValid <= 1'b0;
			execState <= execIdle;
			exInstr <= '0;
			exPc <= `resetPc;
		end
		else
		begin
			execState <= (execValid && !commitReady) ? execWait : execIdle;
			if (issueReady)
				execValid <= issueValid;
			if (issueValid && issueReady)
			begin
				exInstr <= issueInstr;
				exPc <= issuePc;
			end
		end
	end

	////////////////////
	// datapath
	////////////////////

	assign rsVal = rf[exInstr[25:21]];
	assign rtVal = rf[exInstr[20:16]];
	assign pcPlus4 = exPc + 32'd4;

	always_comb
	begin
		case (extCtrl)
			2'b00: extOut = {16'b0, exInstr[15:0]};
			2'b01: extOut = {{16{exInstr[15]}}, exInstr[15:0]};
			2'b10: extOut = {exInstr[15:0], 16'b0};
			default: extOut = '0;
		endcase
	end

	assign aluB = aluBSel ? extOut : rtVal;

	always_comb
	begin
		case (aluCtrl)
			`aluAdd: aluResult = rsVal + aluB;
			`aluSub: aluResult = rsVal - aluB;
			// shift amount from the shamt field
			`aluSll: aluResult = aluB << exInstr[10:6];
			`aluOr: aluResult = rsVal | aluB;
			`aluEq: aluResult = {31'b0, rsVal == aluB};
			default: aluResult = '0;
		endcase
	end

	// link value or extender output, then over the alu
	assign eResult = eResultSel ? (dImmSel ? pcPlus4 : extOut) : aluResult;
	assign memIdx = aluResult[memIdxW+1:2];
	assign memRdData = (slCtrl == `slword) ? dmem[memIdx] : '0;
	assign memWe = dmWe && (slCtrl == `slword);
	assign wbData = dataWbSel ? memRdData : eResult;

	always_comb
	begin
		case (a3Sel)
			2'b00: wrReg = exInstr[15:11];
			2'b01: wrReg = exInstr[20:16];
			2'b10: wrReg = 5'd31;
			default: wrReg = '0;
		endcase
	end

	// no delay slot, targets are relative to pc+4
	always_comb
	begin
		if (isBr && aluResult[0])
			nextPc = pcPlus4 + {{14{exInstr[15]}}, exInstr[15:0], 2'b00};
		else if (jump && jType)
			nextPc = {pcPlus4[31:28], exInstr[25:0], 2'b00};
		else if (jump)
			nextPc = rsVal;
		else
			nextPc = pcPlus4;
	end

	////////////////////
	// state updates
	////////////////////

	// writes land only when commit takes the record
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 32; i++)
				rf[i] <= '0;
		end
		else if (handoff && regWe && wrReg != 5'd0)
			rf[wrReg] <= wbData;
	end

	always_ff @(posedge clk)
	begin
		if (handoff && memWe)
			dmem[memIdx] <= rtVal;
	end

	assign commitPc = exPc;
	assign commitNextPc = nextPc;
	assign commitRegWe = regWe;
	assign commitWrReg = wrReg;
	assign commitWrData = wbData;
	assign commitMemWe = memWe;
	assign commitMemAddr = aluResult;
	assign commitMemData = rtVal;

endmodule

// ==== commitOut.sv ====
`timescale 1ns/1ps

module commitOut import isaPkg::*; (
	input logic clk,
	input logic arstN,
	input logic commitValid,
	output logic commitReady,
	input word commitPc,
	input word commitNextPc,
	input logic commitRegWe,
	input regAddr commitWrReg,
	input word commitWrData,
	input logic commitMemWe,
	input word commitMemAddr,
	input word commitMemData,
	output logic outValid,
	input logic outReady,
	output word outPc,
	output word outNextPc,
	output logic outRegWe,
	output regAddr outWrReg,
	output word outWrData,
	output logic outMemWe,
	output word outMemAddr,
	output word outMemData
);

	logic load;

	// empty, or draining this cycle
	assign commitReady = !outValid || outReady;
	assign load = commitValid && commitReady;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else if (load)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	// record frozen while outside stalls
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			outPc <= commitPc;
			outNextPc <= commitNextPc;
			outRegWe <= commitRegWe;
			outWrReg <= commitWrReg;
			outWrData <= commitWrData;
			outMemWe <= commitMemWe;
			outMemAddr <= commitMemAddr;
			outMemData <= commitMemData;
		end
	end

endmodule

// ==== mipsLite.sv ====
`timescale 1ns/1ps

module mipsLite import isaPkg::*; (
	input logic clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input word inInstr,
	input word inPc,
	output logic outValid,
	input logic outReady,
	output word outPc,
	output word outNextPc,
	output logic outRegWe,
	output regAddr outWrReg,
	output word outWrData,
	output logic outMemWe,
	output word outMemAddr,
	output word outMemData
);

	// intake to execute
	logic issueValid, issueReady;
	word issueInstr, issuePc;

	// execute to commit
	logic commitValid, commitReady, commitRegWe, commitMemWe;
	word commitPc, commitNextPc, commitWrData, commitMemAddr, commitMemData;
	regAddr commitWrReg;

	instrIntake u_instrIntake (
		.clk(clk), .arstN(arstN),
		.inValid(inValid), .inReady(inReady), .inInstr(inInstr), .inPc(inPc),
		.issueValid(issueValid), .issueReady(issueReady),
		.issueInstr(issueInstr), .issuePc(issuePc)
	);

	execCore u_execCore (
		.clk(clk), .arstN(arstN),
		.issueValid(issueValid), .issueReady(issueReady),
		.issueInstr(issueInstr), .issuePc(issuePc),
		.commitValid(commitValid), .commitReady(commitReady),
		.commitPc(commitPc), .commitNextPc(commitNextPc),
		.commitRegWe(commitRegWe), .commitWrReg(commitWrReg), .commitWrData(commitWrData),
		.commitMemWe(commitMemWe), .commitMemAddr(commitMemAddr), .commitMemData(commitMemData)
	);

	commitOut u_commitOut (
		.clk(clk), .arstN(arstN),
		.commitValid(commitValid), .commitReady(commitReady),
		.commitPc(commitPc), .commitNextPc(commitNextPc),
		.commitRegWe(commitRegWe), .commitWrReg(commitWrReg), .commitWrData(commitWrData),
		.commitMemWe(commitMemWe), .commitMemAddr(commitMemAddr), .commitMemData(commitMemData),
		.outValid(outValid), .outReady(outReady),
		.outPc(outPc), .outNextPc(outNextPc),
		.outRegWe(outRegWe), .outWrReg(outWrReg), .outWrData(outWrData),
		.outMemWe(outMemWe), .outMemAddr(outMemAddr), .outMemData(outMemData)
	);

endmodule

// ==== mipsLite_assert.sv ====
`timescale 1ns/1ps

module mipsLiteAssert import isaPkg::*; (
	input logic clk,
	input logic arstN,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input word outPc,
	input word outNextPc,
	input logic outRegWe,
	input regAddr outWrReg,
	input word outWrData,
	input logic outMemWe,
	input word outMemAddr,
	input word outMemData
);

	// whole out record as one vector
	logic [166:0] outRec;

	assign outRec = {outPc, outNextPc, outRegWe, outWrReg, outWrData,
		outMemWe, outMemAddr, outMemData};

	// stalled record holds still and stays offered
	recordHeld: assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(outRec))
		else $error("out record changed while the consumer stalled");

	validKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(outValid))
		else $error("outValid is unknown after reset");

	// intake closed while reset is held
	resetClosed: assert property (@(posedge clk) !arstN |-> !inReady)
		else $error("inReady is high during reset");

endmodule

// ==== tb_mipsLite.sv ====
`timescale 1ns/1ps
`include "mipsLite_defs.svh"

module tb_mipsLite import isaPkg::*; ();

	localparam int clkPeriod = 8;
	// about 60 instructions at the worst stall rate, margin included
	localparam int maxInstr = 60;
	localparam int worstCycles = 208;

	logic clk, arstN, inValid, inReady, outValid, outReady;
	word inInstr, inPc;
	word outPc, outNextPc, outWrData, outMemAddr, outMemData;
	logic outRegWe, outMemWe;
	regAddr outWrReg;

	int seed, errCount, checkCount;
	logic holdReady;
	// feeder pc, follows the reported next pc
	word pc, lastNextPc;
	// constants built by the arithmetic test
	word valA, valB;

	mipsLite u_mipsLite (
		.clk(clk), .arstN(arstN),
		.inValid(inValid), .inReady(inReady), .inInstr(inInstr), .inPc(inPc),
		.outValid(outValid), .outReady(outReady), .outPc(outPc), .outNextPc(outNextPc),
		.outRegWe(outRegWe), .outWrReg(outWrReg), .outWrData(outWrData),
		.outMemWe(outMemWe), .outMemAddr(outMemAddr), .outMemData(outMemData)
	);

	bind mipsLite mipsLiteAssert u_mipsLiteAssert (
		.clk(clk), .arstN(arstN), .inReady(inReady),
		.outValid(outValid), .outReady(outReady), .outPc(outPc), .outNextPc(outNextPc),
		.outRegWe(outRegWe), .outWrReg(outWrReg), .outWrData(outWrData),
		.outMemWe(outMemWe), .outMemAddr(outMemAddr), .outMemData(outMemData)
	);

	////////////////////
	// clock, stalls, watchdog
	////////////////////

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// random out stalls, roughly one cycle in four
	initial
	begin
		forever
		begin
			@(posedge clk);
			#1;
			if (!holdReady)
				outReady = (($random(seed) & 3) != 0);
		end
	end

	initial
	begin
		#(maxInstr * worstCycles * clkPeriod);
		$display("timeout, the DUT stopped making progress at %0t", $time);
		$display("Result: FAILED");
		$finish;
	end

	////////////////////
	// encoders and checks
	////////////////////

	function automatic word rInstr(input regAddr rs, input regAddr rt, input regAddr rd,
			input logic [4:0] sh, input functT fn);
		return {`opcodeR, rs, rt, rd, sh, fn};
	endfunction

	function automatic word iInstr(input opcodeT op, input regAddr rs, input regAddr rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word jInstr(input opcodeT op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	// region of pc+4 joined to the index
	function automatic word jumpTarget(input word atPc, input logic [25:0] idx);
		word pc4;
		pc4 = atPc + 32'd4;
		return {pc4[31:28], idx, 2'b00};
	endfunction

	function automatic logic [166:0] outRecord();
		return {outPc, outNextPc, outRegWe, outWrReg, outWrData, outMemWe, outMemAddr, outMemData};
	endfunction

	task automatic checkVal(input string what, input word got, input word exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errCount++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkTrue(input string what, input logic cond);
		checkCount++;
		assert (cond)
		else
		begin
			errCount++;
			$display("ERR %0t: %s", $time, what);
		end
	endtask

	////////////////////
	// feeder and collector
	////////////////////

	// called 1 ns after a rising edge, returns the same way
	task automatic sendInstr(input word atPc, input word instr);
		logic taken;
		inValid = 1'b1;
		inInstr = instr;
		inPc = atPc;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = inReady;
			@(posedge clk);
			#1;
		end
		inValid = 1'b0;
	endtask

	task automatic collectRecord(input word expPc, input word expNext, input logic expRegWe,
			input regAddr expReg, input word expData, input logic expMemWe,
			input word expAddr, input word expMemData);
		do
		begin
			@(negedge clk);
		end
		while (!(outValid && outReady));
		checkVal("pc", outPc, expPc);
		checkVal("nextPc", outNextPc, expNext);
		checkVal("regWe", {31'b0, outRegWe}, {31'b0, expRegWe});
		checkVal("memWe", {31'b0, outMemWe}, {31'b0, expMemWe});
		// fields only matter when the matching write is on
		if (expRegWe)
		begin
			checkVal("wrReg", {27'b0, outWrReg}, {27'b0, expReg});
			checkVal("wrData", outWrData, expData);
		end
		if (expMemWe)
		begin
			checkVal("memAddr", outMemAddr, expAddr);
			checkVal("memData", outMemData, expMemData);
		end
		lastNextPc = outNextPc;
		@(posedge clk);
		#1;
	endtask

	task automatic runInstr(input word instr, input word expNext, input logic expRegWe,
			input regAddr expReg, input word expData, input logic expMemWe,
			input word expAddr, input word expMemData);
		sendInstr(pc, instr);
		collectRecord(pc, expNext, expRegWe, expReg, expData, expMemWe, expAddr, expMemData);
		pc = lastNextPc;
	endtask

	task automatic runRegWrite(input word instr, input regAddr rd, input word data);
		runInstr(instr, pc + 32'd4, 1'b1, rd, data, 1'b0, '0, '0);
	endtask

	task automatic runNoWrite(input word instr, input word expNext);
		runInstr(instr, expNext, 1'b0, 5'd0, '0, 1'b0, '0, '0);
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic testArith();
		valA = 32'h0000_8234;
		valB = 32'habcd_0000;
		// ori zero-extends, lui fills the upper half
		runRegWrite(iInstr(`opcodeORI, 5'd0, 5'd1, 16'h8234), 5'd1, valA);
		runRegWrite(iInstr(`opcodeLUI, 5'd0, 5'd2, 16'habcd), 5'd2, valB);
		runRegWrite(rInstr(5'd1, 5'd2, 5'd3, 5'd0, `functADDU), 5'd3, valA + valB);
		runRegWrite(rInstr(5'd2, 5'd1, 5'd4, 5'd0, `functSUBU), 5'd4, valB - valA);
		runRegWrite(rInstr(5'd0, 5'd1, 5'd5, 5'd4, `functSLL), 5'd5, valA << 4);
	endtask

	task automatic testMemory();
		// base 0x10, one slot above and one below
		runRegWrite(iInstr(`opcodeORI, 5'd0, 5'd6, 16'h0010), 5'd6, 32'h10);
		runInstr(iInstr(`opcodeSW, 5'd6, 5'd3, 16'h0008), pc + 32'd4, 1'b0, 5'd0, '0,
			1'b1, 32'h18, valA + valB);
		runRegWrite(iInstr(`opcodeLW, 5'd6, 5'd7, 16'h0008), 5'd7, valA + valB);
		runInstr(iInstr(`opcodeSW, 5'd6, 5'd5, 16'hfffc), pc + 32'd4, 1'b0, 5'd0, '0,
			1'b1, 32'h0c, valA << 4);
		runRegWrite(iInstr(`opcodeLW, 5'd6, 5'd12, 16'hfffc), 5'd12, valA << 4);
	endtask

	task automatic testControl();
		word linkPc;
		runNoWrite(iInstr(`opcodeBEQ, 5'd1, 5'd1, 16'd3), pc + 32'd16);
		runNoWrite(iInstr(`opcodeBEQ, 5'd1, 5'd2, 16'd3), pc + 32'd4);
		// backward branch
		runNoWrite(iInstr(`opcodeBEQ, 5'd0, 5'd0, 16'hfffe), pc - 32'd4);
		runNoWrite(jInstr(`opcodeJ, 26'h0000c40), jumpTarget(pc, 26'h0000c40));
		linkPc = pc + 32'd4;
		runInstr(jInstr(`opcodeJAL, 26'h0000c80), jumpTarget(pc, 26'h0000c80), 1'b1, 5'd31,
			linkPc, 1'b0, '0, '0);
		runNoWrite(rInstr(5'd31, 5'd0, 5'd0, 5'd0, `functJR), linkPc);
	endtask

	task automatic testBackpressure();
		word basePc;
		logic [166:0] snap;
		basePc = pc;
		@(negedge clk);
		holdReady = 1'b1;
		@(posedge clk);
		#1;
		outReady = 1'b0;
		fork
			begin
				for (int k = 0; k < 4; k++)
					sendInstr(basePc + 32'(4 * k),
						iInstr(`opcodeORI, 5'd0, regAddr'(8 + k), 16'(256 + k)));
			end
			begin
				do
				begin
					@(negedge clk);
				end
				while (!outValid);
				snap = outRecord();
				repeat (10)
				begin
					@(negedge clk);
					checkTrue("out record changed while stalled", outValid && snap === outRecord());
				end
				// intake, execute and commit each hold one
				checkTrue("inReady still high with all stages full", !inReady);
				@(posedge clk);
				#1;
				outReady = 1'b1;
				for (int k = 0; k < 4; k++)
					collectRecord(basePc + 32'(4 * k), basePc + 32'(4 * k + 4), 1'b1,
						regAddr'(8 + k), 32'(256 + k), 1'b0, '0, '0);
			end
		join
		pc = basePc + 32'd16;
		@(negedge clk);
		holdReady = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic testUnknown();
		runNoWrite(iInstr(6'h3f, 5'd1, 5'd2, 16'h1234), pc + 32'd4);
		runNoWrite(rInstr(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), pc + 32'd4);
		// r3 untouched by the bad funct
		runRegWrite(rInstr(5'd3, 5'd0, 5'd10, 5'd0, `functADDU), 5'd10, valA + valB);
		// reported, but r0 stays zero
		runRegWrite(rInstr(5'd1, 5'd2, 5'd0, 5'd0, `functADDU), 5'd0, valA + valB);
		runRegWrite(rInstr(5'd0, 5'd0, 5'd9, 5'd0, `functADDU), 5'd9, 32'd0);
	endtask

	initial
	begin
		seed = 32'hc329fc44;
		errCount = 0;
		checkCount = 0;
		holdReady = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		inPc = '0;
		outReady = 1'b0;
		pc = `resetPc;
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;
		@(posedge clk);
		#1;
		testArith();
		testMemory();
		testControl();
		testBackpressure();
		testUnknown();
		$display("checks run %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
isaPkg.sv
corePkg.sv
mainController.sv
instrIntake.sv
execCore.sv
commitOut.sv
mipsLite.sv
mipsLite_assert.sv
tb_mipsLite.sv

// ==== Makefile ====
SIM   := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_mipsLite
FLIST := flist.f
PASS  := Result: PASSED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir
